/* bbc_config.svh */
// build-time constants for the BBC Micro glue logic
// memory sizes must match the core's external address map
// divider ratios assume clk_sys runs at 96 MHz
// mouse limits are in PS/2 counts, axis limits in signed position units
`ifndef BBC_CONFIG_SVH
`define BBC_CONFIG_SVH

// ====================
// memory geometry
// ====================
// physical ROM banks behind the remap table
`define BBC_ROM_BANKS 14
// address bits inside one 16K bank
`define BBC_BANK_ADDR_W 14
// shadow, sideways and main RAM together
`define BBC_RAM_BYTES 212992

// ====================
// clock enables, mouse, SD
// ====================
// 96/4 = 24 MHz, 96/3 = 32 MHz
`define BBC_CE24_DIV 4
`define BBC_CE32_DIV 3
// step limit per packet and accumulated range
`define BBC_MOUSE_STEP_MAX 10
`define BBC_AXIS_MIN (-128)
`define BBC_AXIS_MAX 127
// activity LED hold, about 20 ms at 96 MHz
`define BBC_SD_ACT_CYCLES 2000000

`endif

/* bbc_mem_pkg.sv */
// memory-side types shared by the glue top and the external memory
// the core drives a 19-bit byte address, RAM when bit 18 is set
// ROM addresses are physical, after the bank remap
package bbc_mem_pkg;

	// ====================
	// addresses
	// ====================
	// core external address
	// bit 18 selects RAM, bits 17:14 are the sideways slot
	typedef logic [18:0] mem_addr_t;

	// physical ROM address, bank in the top four bits
	typedef logic [17:0] rom_addr_t;

	// physical bank index, 0..13 in use
	typedef logic [3:0] bank_t;

	// ====================
	// data and model
	// ====================
	// byte wide data on every memory path
	typedef logic [7:0] byte_t;

	// machine model, picks the remap column
	// model_b is the power-on default
	typedef enum logic {
		model_b      = 1'b0,
		model_master = 1'b1
	} model_e;

endpackage

/* bbc_io_pkg.sv */
// input-side types for the mouse and joystick path
// the mouse packet follows the host PS/2 layout with a toggle strobe
// axis values are signed and kept inside the limits of bbc_config.svh
package bbc_io_pkg;

	// ====================
	// mouse
	// ====================
	// [24]    toggle strobe, one change per packet
	// [23:16] Y delta, sign in bit 5
	// [15:8]  X delta, sign in bit 4
	// [1:0]   right and left buttons
	typedef logic [24:0] mouse_pkt_t;

	// accumulated position, one spare bit above the clamp range
	typedef logic signed [8:0] axis_t;

	// ====================
	// joystick
	// ====================
	// host analog stick byte, two's complement around 0
	typedef logic [7:0] joy_byte_t;

	// 12-bit core ADC value
	// byte in the top eight bits, its upper nibble repeated below
	typedef logic [11:0] joy_axis_t;

endpackage

/* bbc_clock_enables.sv */
// clock-enable pulses for the core's 24 and 32 MHz domains
// both are one clk_sys cycle wide and rising-edge timed
// both stay low in reset, first pulse right after release
`timescale 1ns/1ps
`include "bbc_config.svh"

module bbc_clock_enables (
	input  logic clk_sys,
	input  logic rst_n,
	output logic ce_24,
	output logic ce_32
);

	localparam int unsigned CE24_W = $clog2(`BBC_CE24_DIV);
	localparam int unsigned CE32_W = $clog2(`BBC_CE32_DIV);

	// free-running phase counters
	logic [CE24_W-1:0] cnt_24;
	logic [CE32_W-1:0] cnt_32;

	// enable registered from phase zero
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_24 <= '0;
			cnt_32 <= '0;
			ce_24  <= 1'b0;
			ce_32  <= 1'b0;
		end else begin
			ce_24 <= (cnt_24 == '0);
			ce_32 <= (cnt_32 == '0);
			// wrap at the divide ratio
			if (cnt_24 == CE24_W'(`BBC_CE24_DIV - 1))
				cnt_24 <= '0;
			else
				cnt_24 <= cnt_24 + 1'b1;
			if (cnt_32 == CE32_W'(`BBC_CE32_DIV - 1))
				cnt_32 <= '0;
			else
				cnt_32 <= cnt_32 + 1'b1;
		end
	end

	// gated core clocks rely on single-cycle enables
	a_ce24_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_24 |=> !ce_24);
	a_ce32_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_32 |=> !ce_32);

endmodule

/* bbc_ext_memory.sv */
// external memory of the core: remapped ROM banks and the RAM array
// read data is registered, valid one cycle after mem_addr
// RAM writes fire once per falling edge of mem_we_n
// ROM loads only while the host holds the core in reset
// RAM addresses past BBC_RAM_BYTES are not decoded
`timescale 1ns/1ps
`include "bbc_config.svh"

module bbc_ext_memory (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  bbc_mem_pkg::model_e    model,
	input  bbc_mem_pkg::mem_addr_t mem_addr,
	input  logic                  mem_we_n,
	input  bbc_mem_pkg::byte_t     mem_din,
	output bbc_mem_pkg::byte_t     mem_dout,
	input  logic                  load_hold,
	input  logic                  rom_load_wr,
	input  bbc_mem_pkg::rom_addr_t rom_load_addr,
	input  bbc_mem_pkg::byte_t     rom_load_data
);

	import bbc_mem_pkg::*;

	localparam int unsigned ROM_BYTES = `BBC_ROM_BANKS * (2 ** `BBC_BANK_ADDR_W);

	byte_t     rom [ROM_BYTES];
	byte_t     ram [`BBC_RAM_BYTES];

	logic [3:0] slot;
	bank_t      bank;
	logic       slot_hit;
	rom_addr_t  rom_rd_addr;
	logic       ram_we;

	byte_t      rom_q;
	byte_t      ram_q;
	logic       hit_q;
	logic       ram_sel_q;
	logic       we_n_q;

	// ====================
	// bank remap
	// ====================
	assign slot = mem_addr[17:14];

	// sideways slot to physical bank, per model
	always_comb begin
		bank     = '0;
		slot_hit = 1'b1;
		case ({model, slot})
			// model B: MOS, MMFS, RAM master, BASIC 2
			{model_b, 4'b0100}:      bank = 4'd0;
			{model_b, 4'b1000}:      bank = 4'd1;
			{model_b, 4'b1110}:      bank = 4'd2;
			{model_b, 4'b1111}:      bank = 4'd3;
			// master 128 set
			{model_master, 4'b0010}: bank = 4'd4;
			{model_master, 4'b0011}: bank = 4'd5;
			{model_master, 4'b0100}: bank = 4'd6;
			{model_master, 4'b1001}: bank = 4'd7;
			{model_master, 4'b1010}: bank = 4'd8;
			{model_master, 4'b1011}: bank = 4'd9;
			{model_master, 4'b1100}: bank = 4'd10;
			{model_master, 4'b1101}: bank = 4'd11;
			{model_master, 4'b1110}: bank = 4'd12;
			{model_master, 4'b1111}: bank = 4'd13;
			// empty slot, reads as zero
			default:                 slot_hit = 1'b0;
		endcase
	end

	assign rom_rd_addr = {bank, mem_addr[`BBC_BANK_ADDR_W-1:0]};

	// ====================
	// ROM array
	// ====================
	// download port shares the array with the read side
	always_ff @(posedge clk_sys) begin
		if (load_hold && rom_load_wr)
			rom[rom_load_addr] <= rom_load_data;
		rom_q <= rom[rom_rd_addr];
	end

	// ====================
	// RAM array
	// ====================
	// first low cycle of the strobe only
	assign ram_we = mem_addr[18] && we_n_q && !mem_we_n;

	always_ff @(posedge clk_sys) begin
		if (ram_we)
			ram[mem_addr[17:0]] <= mem_din;
		ram_q <= ram[mem_addr[17:0]];
	end

	// strobe history and read steering, aligned with the array outputs
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			we_n_q    <= 1'b1;
			hit_q     <= 1'b0;
			ram_sel_q <= 1'b0;
		end else begin
			we_n_q    <= mem_we_n;
			hit_q     <= slot_hit;
			ram_sel_q <= mem_addr[18];
		end
	end

	// RAM wins, then a mapped ROM bank, else zero
	assign mem_dout = ram_sel_q ? ram_q : (hit_q ? rom_q : '0);

	// host must hold the core in reset around a download
	a_load_in_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rom_load_wr |-> load_hold);
	// core never writes past the fitted RAM
	a_ram_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ram_we |-> (mem_addr[17:0] < `BBC_RAM_BYTES));

endmodule

/* bbc_mouse_axis.sv */
// PS/2 mouse as analog joystick for the core's ADC inputs
// each strobe toggle adds a clamped step to the X and Y positions
// joy_active, reset_req or mouse_disable hand control back to the host
// outputs follow a strobe toggle by one cycle
`timescale 1ns/1ps
`include "bbc_config.svh"

module bbc_mouse_axis (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  bbc_io_pkg::mouse_pkt_t mouse,
	input  bbc_io_pkg::joy_byte_t  host_x,
	input  bbc_io_pkg::joy_byte_t  host_y,
	input  logic                   host_fire,
	input  logic                   joy_active,
	input  logic                   reset_req,
	input  logic                   mouse_disable,
	output bbc_io_pkg::joy_axis_t  axis_x,
	output bbc_io_pkg::joy_axis_t  axis_y,
	output logic                   fire_n
);

	import bbc_io_pkg::*;

	// saturate an int into the given range
	function automatic axis_t sat(input int v, input int lo, input int hi);
		if (v < lo)
			return axis_t'(lo);
		if (v > hi)
			return axis_t'(hi);
		return axis_t'(v);
	endfunction

	logic      stb_q;
	logic      toggle;
	logic      emu;
	logic      release_req;
	axis_t     pos_x;
	axis_t     pos_y;
	axis_t     dx_raw;
	axis_t     dy_raw;
	axis_t     dx;
	axis_t     dy;
	axis_t     nx;
	axis_t     ny;
	joy_byte_t src_x;
	joy_byte_t src_y;
	joy_byte_t adc_x;
	joy_byte_t adc_y;

	// ====================
	// packet decode
	// ====================
	assign toggle      = (mouse[24] != stb_q);
	assign release_req = joy_active || reset_req || mouse_disable;

	// sign bits sit in the flag byte
	assign dx_raw = {mouse[4], mouse[15:8]};
	assign dy_raw = {mouse[5], mouse[23:16]};

	// fast swipes limited per packet
	assign dx = sat(int'(dx_raw), -`BBC_MOUSE_STEP_MAX, `BBC_MOUSE_STEP_MAX);
	assign dy = sat(int'(dy_raw), -`BBC_MOUSE_STEP_MAX, `BBC_MOUSE_STEP_MAX);

	// PS/2 Y grows upward, the stick grows downward
	assign nx = sat(int'(pos_x) + int'(dx), `BBC_AXIS_MIN, `BBC_AXIS_MAX);
	assign ny = sat(int'(pos_y) - int'(dy), `BBC_AXIS_MIN, `BBC_AXIS_MAX);

	// ====================
	// position state
	// ====================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			stb_q <= 1'b0;
			emu   <= 1'b0;
			pos_x <= '0;
			pos_y <= '0;
		end else begin
			stb_q <= mouse[24];
			// host stick or reset takes over
			if (release_req) begin
				emu   <= 1'b0;
				pos_x <= '0;
				pos_y <= '0;
			end else if (toggle) begin
				emu   <= 1'b1;
				pos_x <= nx;
				pos_y <= ny;
			end
		end
	end

	// ====================
	// output mapping
	// ====================
	assign src_x = emu ? pos_x[7:0] : host_x;
	assign src_y = emu ? pos_y[7:0] : host_y;

	// centre 0 becomes 127, full left or up reads high
	assign adc_x = 8'd127 - src_x;
	assign adc_y = 8'd127 - src_y;

	// widen to the 12-bit ADC range
	assign axis_x = {adc_x, adc_x[7:4]};
	assign axis_y = {adc_y, adc_y[7:4]};

	// either mouse button fires, active low at the core
	assign fire_n = ~(emu ? |mouse[1:0] : host_fire);

	a_pos_range: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(pos_x >= `BBC_AXIS_MIN) && (pos_x <= `BBC_AXIS_MAX) &&
		(pos_y >= `BBC_AXIS_MIN) && (pos_y <= `BBC_AXIS_MAX));

endmodule

/* bbc_sd_route.sv */
// SPI routing between the virtual SD image and the physical card
// image selection latches on img_mounted only
// physical lines are parked with CS high while the image is used
// activity counts clk_sys cycles since the last MOSI or MISO change
`timescale 1ns/1ps
`include "bbc_config.svh"

module bbc_sd_route #(
	parameter int unsigned act_cycles = `BBC_SD_ACT_CYCLES
) (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic img_mounted,
	input  logic img_size_nz,
	input  logic core_sck,
	input  logic core_mosi,
	input  logic core_ss,
	output logic core_miso,
	input  logic vsd_miso,
	input  logic SD_MISO,
	output logic SD_SCK,
	output logic SD_MOSI,
	output logic SD_CS,
	output logic led_user,
	output logic led_disk
);

	localparam int unsigned ACT_W = $clog2(act_cycles + 1);

	logic             vsd_sel;
	logic             mosi_q;
	logic             miso_q;
	logic             line_edge;
	logic [ACT_W-1:0] act_cnt;
	logic             sd_act;

	// ====================
	// card select and SPI mux
	// ====================
	// empty mount falls back to the physical card
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			vsd_sel <= 1'b0;
		else if (img_mounted)
			vsd_sel <= img_size_nz;
	end

	assign core_miso = vsd_sel ? vsd_miso : SD_MISO;

	// deselect and idle the real card
	assign SD_CS   = core_ss | vsd_sel;
	assign SD_SCK  = core_sck & ~vsd_sel;
	assign SD_MOSI = core_mosi & ~vsd_sel;

	// ====================
	// activity timer
	// ====================
	assign line_edge = (core_mosi != mosi_q) || (core_miso != miso_q);

	// starts saturated so the LEDs stay dark until traffic
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			mosi_q  <= 1'b0;
			miso_q  <= 1'b0;
			act_cnt <= ACT_W'(act_cycles);
		end else begin
			mosi_q <= core_mosi;
			miso_q <= core_miso;
			if (line_edge)
				act_cnt <= '0;
			else if (act_cnt < ACT_W'(act_cycles))
				act_cnt <= act_cnt + 1'b1;
		end
	end

	assign sd_act = (act_cnt < ACT_W'(act_cycles));

	// user LED for the image, disk LED for the card
	assign led_user = sd_act & vsd_sel;
	assign led_disk = sd_act & ~vsd_sel;

endmodule

/* bbc_glue_top.sv */
// glue between the host platform and an external BBC Micro core
// the model is sampled only while the core requests a reset
// act_cycles sets the SD activity hold in clk_sys cycles
`timescale 1ns/1ps
`include "bbc_config.svh"

module bbc_glue_top #(
	parameter int unsigned act_cycles = `BBC_SD_ACT_CYCLES
) (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  bbc_mem_pkg::model_e     model_sel,
	input  logic                   reset_req,
	// core memory bus
	input  bbc_mem_pkg::mem_addr_t  mem_addr,
	input  logic                   mem_we_n,
	input  bbc_mem_pkg::byte_t      mem_din,
	output bbc_mem_pkg::byte_t      mem_dout,
	// ROM download
	input  logic                   load_hold,
	input  logic                   rom_load_wr,
	input  bbc_mem_pkg::rom_addr_t  rom_load_addr,
	input  bbc_mem_pkg::byte_t      rom_load_data,
	// mouse and host joystick
	input  bbc_io_pkg::mouse_pkt_t  mouse,
	input  bbc_io_pkg::joy_byte_t   host_x,
	input  bbc_io_pkg::joy_byte_t   host_y,
	input  logic                   host_fire,
	input  logic                   joy_active,
	input  logic                   mouse_disable,
	output bbc_io_pkg::joy_axis_t   axis_x,
	output bbc_io_pkg::joy_axis_t   axis_y,
	output logic                   fire_n,
	// SD card
	input  logic                   img_mounted,
	input  logic                   img_size_nz,
	input  logic                   core_sck,
	input  logic                   core_mosi,
	input  logic                   core_ss,
	output logic                   core_miso,
	input  logic                   vsd_miso,
	input  logic                   SD_MISO,
	output logic                   SD_SCK,
	output logic                   SD_MOSI,
	output logic                   SD_CS,
	output logic                   led_user,
	output logic                   led_disk,
	// core clock enables
	output logic                   ce_24,
	output logic                   ce_32
);

	import bbc_mem_pkg::*;

	model_e model_q;

	// model switch takes effect through a core reset
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			model_q <= model_b;
		else if (reset_req)
			model_q <= model_sel;
	end

	// ====================
	// blocks
	// ====================
	bbc_clock_enables i_clock_enables (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.ce_24   (ce_24),
		.ce_32   (ce_32)
	);

	bbc_ext_memory i_ext_memory (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.model         (model_q),
		.mem_addr      (mem_addr),
		.mem_we_n      (mem_we_n),
		.mem_din       (mem_din),
		.mem_dout      (mem_dout),
		.load_hold     (load_hold),
		.rom_load_wr   (rom_load_wr),
		.rom_load_addr (rom_load_addr),
		.rom_load_data (rom_load_data)
	);

	bbc_mouse_axis i_mouse_axis (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.mouse         (mouse),
		.host_x        (host_x),
		.host_y        (host_y),
		.host_fire     (host_fire),
		.joy_active    (joy_active),
		.reset_req     (reset_req),
		.mouse_disable (mouse_disable),
		.axis_x        (axis_x),
		.axis_y        (axis_y),
		.fire_n        (fire_n)
	);

	bbc_sd_route #(
		.act_cycles (act_cycles)
	) i_sd_route (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.img_mounted (img_mounted),
		.img_size_nz (img_size_nz),
		.core_sck    (core_sck),
		.core_mosi   (core_mosi),
		.core_ss     (core_ss),
		.core_miso   (core_miso),
		.vsd_miso    (vsd_miso),
		.SD_MISO     (SD_MISO),
		.SD_SCK      (SD_SCK),
		.SD_MOSI     (SD_MOSI),
		.SD_CS       (SD_CS),
		.led_user    (led_user),
		.led_disk    (led_disk)
	);

endmodule

/* tb_bbc_checker.sv */
// checker for the BBC glue top level, watches every DUT port
// samples 1 ns after each rising clk_sys edge, when inputs and outputs are settled
// reference models follow the remap, RAM, mouse and SD rules
// unloaded ROM and unwritten RAM locations are not compared
`timescale 1ns/1ps

module tb_bbc_checker #(
	parameter int act_cycles = 64
) (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  bbc_mem_pkg::model_e    model_sel,
	input  logic                   reset_req,
	input  bbc_mem_pkg::mem_addr_t mem_addr,
	input  logic                   mem_we_n,
	input  bbc_mem_pkg::byte_t     mem_din,
	input  bbc_mem_pkg::byte_t     mem_dout,
	input  logic                   load_hold,
	input  logic                   rom_load_wr,
	input  bbc_mem_pkg::rom_addr_t rom_load_addr,
	input  bbc_mem_pkg::byte_t     rom_load_data,
	input  bbc_io_pkg::mouse_pkt_t mouse,
	input  bbc_io_pkg::joy_byte_t  host_x,
	input  bbc_io_pkg::joy_byte_t  host_y,
	input  logic                   host_fire,
	input  logic                   joy_active,
	input  logic                   mouse_disable,
	input  bbc_io_pkg::joy_axis_t  axis_x,
	input  bbc_io_pkg::joy_axis_t  axis_y,
	input  logic                   fire_n,
	input  logic                   img_mounted,
	input  logic                   img_size_nz,
	input  logic                   core_sck,
	input  logic                   core_mosi,
	input  logic                   core_ss,
	input  logic                   core_miso,
	input  logic                   vsd_miso,
	input  logic                   SD_MISO,
	input  logic                   SD_SCK,
	input  logic                   SD_MOSI,
	input  logic                   SD_CS,
	input  logic                   led_user,
	input  logic                   led_disk,
	input  logic                   ce_24,
	input  logic                   ce_32,
	output int                     errors,
	output int                     checks
);

	import bbc_mem_pkg::*;
	import bbc_io_pkg::*;

	localparam int ROM_SIZE = 14 * 16384;
	localparam int RAM_SIZE = 212992;

	// shadow memories with written flags
	byte_t  rom_m [ROM_SIZE];
	bit     rom_v [ROM_SIZE];
	byte_t  ram_m [RAM_SIZE];
	bit     ram_v [RAM_SIZE];
	model_e model_m;
	logic   we_n_m;

	// mouse and SD state
	logic   stb_m;
	logic   emu_m;
	int     pos_x_m;
	int     pos_y_m;
	logic   vsd_m;
	logic   mosi_m;
	logic   miso_m;
	int     idle_m;

	// enable pulse bookkeeping
	int     cyc;
	int     n24;
	int     n32;

	// ====================
	// reference functions
	// ====================
	// physical bank of a sideways slot, -1 when empty
	function automatic int bank_of(input model_e m, input logic [3:0] slot);
		if (m == model_b) begin
			case (slot)
				4'h4:    return 0;
				4'h8:    return 1;
				4'hE:    return 2;
				4'hF:    return 3;
				default: return -1;
			endcase
		end
		// master: slots 2..4 sit at banks 4..6, slots 9..15 at 7..13
		if (slot >= 4'h2 && slot <= 4'h4)
			return int'(slot) + 2;
		if (slot >= 4'h9)
			return int'(slot) - 2;
		return -1;
	endfunction

	function automatic int clamp(input int v, input int lo, input int hi);
		if (v < lo)
			return lo;
		if (v > hi)
			return hi;
		return v;
	endfunction

	// nine-bit PS/2 delta, sign from the flag byte
	function automatic int delta(input logic sign, input logic [7:0] mag);
		logic [8:0] raw;
		raw = {sign, mag};
		return raw[8] ? int'(raw) - 512 : int'(raw);
	endfunction

	// 127 - v as a byte, top nibble repeated below
	function automatic logic [11:0] adc_word(input int v);
		int         t;
		logic [7:0] b;
		t = 127 - v;
		b = t[7:0];
		return {b, b[7:4]};
	endfunction

	task automatic compare_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ====================
	// per-block models
	// ====================
	task automatic check_clock_enables();
		cyc++;
		compare_value("ce_24", ce_24, ((cyc - 1) % 4) == 0);
		compare_value("ce_32", ce_32, ((cyc - 1) % 3) == 0);
		if (cyc <= 120) begin
			n24 += ce_24;
			n32 += ce_32;
		end
		if (cyc == 120) begin
			compare_value("ce_24 pulses in 120 cycles", n24, 30);
			compare_value("ce_32 pulses in 120 cycles", n32, 40);
		end
	endtask

	task automatic check_memory();
		int          bank;
		int          key;
		logic        known;
		logic [31:0] exp;
		known = 1'b1;
		exp   = '0;
		bank  = bank_of(model_m, mem_addr[17:14]);
		// read sees the contents before this edge's write
		if (mem_addr[18]) begin
			key = int'(mem_addr[17:0]);
			known = (key < RAM_SIZE) && ram_v[key];
			if (known)
				exp = ram_m[key];
		end else if (bank >= 0) begin
			key = bank * 16384 + int'(mem_addr[13:0]);
			known = rom_v[key];
			if (known)
				exp = rom_m[key];
		end
		if (known)
			compare_value("mem_dout", mem_dout, exp);
		// one write per falling edge of the strobe
		key = int'(mem_addr[17:0]);
		if (mem_addr[18] && we_n_m && !mem_we_n && key < RAM_SIZE) begin
			ram_m[key] = mem_din;
			ram_v[key] = 1'b1;
		end
		we_n_m = mem_we_n;
		key = int'(rom_load_addr);
		if (load_hold && rom_load_wr && key < ROM_SIZE) begin
			rom_m[key] = rom_load_data;
			rom_v[key] = 1'b1;
		end
		if (reset_req)
			model_m = model_sel;
	endtask

	task automatic check_mouse();
		logic tgl;
		int   dx;
		int   dy;
		tgl   = (mouse[24] != stb_m);
		stb_m = mouse[24];
		if (joy_active || reset_req || mouse_disable) begin
			emu_m   = 1'b0;
			pos_x_m = 0;
			pos_y_m = 0;
		end else if (tgl) begin
			dx = clamp(delta(mouse[4], mouse[15:8]), -10, 10);
			dy = clamp(delta(mouse[5], mouse[23:16]), -10, 10);
			emu_m   = 1'b1;
			pos_x_m = clamp(pos_x_m + dx, -128, 127);
			pos_y_m = clamp(pos_y_m - dy, -128, 127);
		end
		compare_value("axis_x", axis_x, adc_word(emu_m ? pos_x_m : int'(host_x)));
		compare_value("axis_y", axis_y, adc_word(emu_m ? pos_y_m : int'(host_y)));
		compare_value("fire_n", fire_n, !(emu_m ? |mouse[1:0] : host_fire));
	endtask

	task automatic check_sd();
		logic miso_sel;
		logic act;
		// MISO as the core saw it before this edge
		miso_sel = vsd_m ? vsd_miso : SD_MISO;
		if (core_mosi != mosi_m || miso_sel != miso_m)
			idle_m = 0;
		else if (idle_m < act_cycles)
			idle_m++;
		mosi_m = core_mosi;
		miso_m = miso_sel;
		if (img_mounted)
			vsd_m = img_size_nz;
		act = (idle_m < act_cycles);
		compare_value("core_miso", core_miso, vsd_m ? vsd_miso : SD_MISO);
		compare_value("SD_CS", SD_CS, vsd_m ? 1'b1 : core_ss);
		compare_value("SD_SCK", SD_SCK, vsd_m ? 1'b0 : core_sck);
		compare_value("SD_MOSI", SD_MOSI, vsd_m ? 1'b0 : core_mosi);
		compare_value("led_user", led_user, act && vsd_m);
		compare_value("led_disk", led_disk, act && !vsd_m);
	endtask

	initial begin
		errors = 0;
		checks = 0;
	end

	always begin
		@(posedge clk_sys);
		#1;
		if (!rst_n) begin
			compare_value("ce_24 in reset", ce_24, 0);
			compare_value("ce_32 in reset", ce_32, 0);
			model_m = model_b;
			we_n_m  = 1'b1;
			stb_m   = 1'b0;
			emu_m   = 1'b0;
			pos_x_m = 0;
			pos_y_m = 0;
			vsd_m   = 1'b0;
			mosi_m  = 1'b0;
			miso_m  = 1'b0;
			idle_m  = act_cycles;
			cyc     = 0;
			n24     = 0;
			n32     = 0;
		end else begin
			check_clock_enables();
			check_memory();
			check_mouse();
			check_sd();
		end
	end

endmodule

/* tb_bbc_glue.sv */
// testbench top for the BBC Micro glue logic
// inputs change on the falling clk_sys edge, tb_bbc_checker compares
// stimulus runs about 820 cycles, the cycle limit is 4000
`timescale 1ns/1ps

module tb_bbc_glue;

	import bbc_mem_pkg::*;
	import bbc_io_pkg::*;

	localparam int ACT        = 64;
	localparam int MAX_CYCLES = 4000;

	logic       clk_sys;
	logic       rst_n;
	model_e     model_sel;
	logic       reset_req;
	mem_addr_t  mem_addr;
	logic       mem_we_n;
	byte_t      mem_din;
	byte_t      mem_dout;
	logic       load_hold;
	logic       rom_load_wr;
	rom_addr_t  rom_load_addr;
	byte_t      rom_load_data;
	mouse_pkt_t mouse;
	joy_byte_t  host_x;
	joy_byte_t  host_y;
	logic       host_fire;
	logic       joy_active;
	logic       mouse_disable;
	joy_axis_t  axis_x;
	joy_axis_t  axis_y;
	logic       fire_n;
	logic       img_mounted;
	logic       img_size_nz;
	logic       core_sck;
	logic       core_mosi;
	logic       core_ss;
	logic       core_miso;
	logic       vsd_miso;
	logic       SD_MISO;
	logic       SD_SCK;
	logic       SD_MOSI;
	logic       SD_CS;
	logic       led_user;
	logic       led_disk;
	logic       ce_24;
	logic       ce_32;

	int          errors;
	int          checks;
	int          cycles = 0;
	logic [15:0] lfsr;
	mem_addr_t   ram_addr [8];

	bbc_glue_top #(.act_cycles(ACT)) i_dut (.*);

	tb_bbc_checker #(.act_cycles(ACT)) i_checker (.*);

	// ====================
	// clock, limit, random
	// ====================
	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("test timed out after %0d cycles", cycles);
			$display("checks %0d, errors %0d", checks, errors);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// start, middle and end of each bank
	function automatic logic [13:0] rom_offset(input int i);
		case (i)
			0:       return 14'h0000;
			1:       return 14'h1a5c;
			default: return 14'h3fff;
		endcase
	endfunction

	// ====================
	// sequences
	// ====================
	task automatic init_inputs();
		rst_n         = 1'b0;
		model_sel     = model_b;
		reset_req     = 1'b0;
		mem_addr      = '0;
		mem_we_n      = 1'b1;
		mem_din       = '0;
		load_hold     = 1'b0;
		rom_load_wr   = 1'b0;
		rom_load_addr = '0;
		rom_load_data = '0;
		mouse         = '0;
		// stick off centre and card selected, so reset values show
		host_x        = 8'h30;
		host_y        = 8'hd0;
		host_fire     = 1'b1;
		joy_active    = 1'b0;
		mouse_disable = 1'b0;
		img_mounted   = 1'b0;
		img_size_nz   = 1'b0;
		core_sck      = 1'b0;
		core_mosi     = 1'b0;
		core_ss       = 1'b0;
		vsd_miso      = 1'b0;
		SD_MISO       = 1'b0;
	endtask

	// model switch goes through a core reset request
	task automatic select_model(input model_e m);
		model_sel = m;
		reset_req = 1'b1;
		@(negedge clk_sys);
		reset_req = 1'b0;
	endtask

	// three offsets in each of the 16 sideways slots
	task automatic read_slots();
		int s;
		int i;
		for (s = 0; s < 16; s++) begin
			for (i = 0; i < 3; i++) begin
				mem_addr = {1'b0, 4'(s), rom_offset(i)};
				@(negedge clk_sys);
			end
		end
	endtask

	task automatic load_and_read_rom();
		logic [31:0] r;
		int          b;
		int          i;
		load_hold = 1'b1;
		@(negedge clk_sys);
		for (b = 0; b < 14; b++) begin
			for (i = 0; i < 3; i++) begin
				take_bits(8, r);
				rom_load_wr   = 1'b1;
				rom_load_addr = {4'(b), rom_offset(i)};
				rom_load_data = r[7:0];
				@(negedge clk_sys);
			end
		end
		rom_load_wr = 1'b0;
		load_hold   = 1'b0;
		// model B from reset, then each model by request
		read_slots();
		select_model(model_master);
		read_slots();
		select_model(model_b);
		read_slots();
	endtask

	task automatic write_and_read_ram();
		logic [31:0] r;
		logic [31:0] d;
		int          i;
		for (i = 0; i < 8; i++) begin
			take_bits(17, r);
			take_bits(8, d);
			ram_addr[i] = {2'b10, r[16:0]};
			mem_addr    = ram_addr[i];
			mem_din     = d[7:0];
			mem_we_n    = 1'b0;
			@(negedge clk_sys);
			// data later in the same low period is ignored
			mem_din = ~d[7:0];
			repeat (3) @(negedge clk_sys);
			mem_we_n = 1'b1;
			@(negedge clk_sys);
		end
		// earlier bytes survive the later writes
		for (i = 0; i < 8; i++) begin
			mem_addr = ram_addr[i];
			@(negedge clk_sys);
		end
	endtask

	task automatic send_packet(input logic xs, input byte_t dx, input logic ys,
		input byte_t dy, input logic [1:0] btn);
		mouse = {~mouse[24], dy, dx, 2'b00, ys, xs, 2'b00, btn};
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic move_mouse();
		logic [31:0] r;
		int          i;
		take_bits(17, r);
		host_x    = r[7:0];
		host_y    = r[15:8];
		host_fire = r[16];
		@(negedge clk_sys);
		for (i = 0; i < 36; i++) begin
			take_bits(12, r);
			// steady swipe right and up into both clamps
			if (i < 16)
				send_packet(1'b0, 8'd40, 1'b0, 8'd35, r[1:0]);
			else
				send_packet(r[2], {4'h0, r[6:3]}, r[7], {4'h0, r[11:8]}, r[1:0]);
		end
		// host stick takes over
		joy_active = 1'b1;
		@(negedge clk_sys);
		take_bits(16, r);
		host_x = r[7:0];
		host_y = r[15:8];
		repeat (3) @(negedge clk_sys);
		joy_active = 1'b0;
		send_packet(1'b1, 8'hf8, 1'b0, 8'd3, 2'b01);
	endtask

	task automatic route_sd();
		int i;
		// image mount, physical card parked
		img_size_nz = 1'b1;
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		core_ss     = 1'b0;
		for (i = 0; i < 8; i++) begin
			core_sck = ~core_sck;
			vsd_miso = ~vsd_miso;
			SD_MISO  = i[1];
			@(negedge clk_sys);
		end
		repeat (80) @(negedge clk_sys);
		// single MOSI edge, user LED for ACT cycles
		core_mosi = ~core_mosi;
		repeat (80) @(negedge clk_sys);
		// empty image falls back to the physical card
		img_size_nz = 1'b0;
		img_mounted = 1'b1;
		@(negedge clk_sys);
		img_mounted = 1'b0;
		repeat (80) @(negedge clk_sys);
		core_mosi = ~core_mosi;
		SD_MISO   = ~SD_MISO;
		core_sck  = 1'b1;
		repeat (80) @(negedge clk_sys);
		core_ss = 1'b1;
	endtask

	initial begin
		init_inputs();
		lfsr = 16'd13;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		// enables run free while nothing else moves
		repeat (124) @(negedge clk_sys);
		load_and_read_rom();
		write_and_read_ram();
		move_mouse();
		route_sd();
		repeat (4) @(negedge clk_sys);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0 && checks > 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* sources.f */
+incdir+.
bbc_mem_pkg.sv
bbc_io_pkg.sv
bbc_clock_enables.sv
bbc_ext_memory.sv
bbc_mouse_axis.sv
bbc_sd_route.sv
bbc_glue_top.sv
tb_bbc_checker.sv
tb_bbc_glue.sv

/* Bender.yml */
package:
  name: bbc_glue

export_include_dirs:
  - .

sources:
  - bbc_mem_pkg.sv
  - bbc_io_pkg.sv
  - bbc_clock_enables.sv
  - bbc_ext_memory.sv
  - bbc_mouse_axis.sv
  - bbc_sd_route.sv
  - bbc_glue_top.sv
  - target: simulation
    files:
      - tb_bbc_checker.sv
      - tb_bbc_glue.sv
